//--- Bender.yml
package:
  name: rename_issue

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isa_pkg.sv
      - hdl/rename_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/rename_table.sv
      - hdl/issue_fsm.sv
      - hdl/recovery_timer.sv
      - hdl/rename_issue.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/rename_issue_props.sv
      - tests/rename_issue_tb.sv

//--- hdl/isa_pkg.sv
// opcode enum, architectural register type, decoded instruction and register file queries
`include "rename_consts.svh"

package isa_pkg;

    // opcode set of the slice, fence last
    typedef enum logic [2:0] {
        ALU      = 3'd0,
        LOAD     = 3'd1,
        STORE    = 3'd2,
        FADD     = 3'd3,
        FMADD    = 3'd4,
        FCVT_F2I = 3'd5,
        FCVT_I2F = 3'd6,
        FENCE    = 3'd7
    } op_e;

    // architectural register number, same width for both files
    typedef logic [$clog2(`NR_ARCH_REGS)-1:0] arch_reg_t;

    // decoded instruction as it waits in the instruction queue
    typedef struct packed {
        op_e       op;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rs3;
        arch_reg_t rd;
    } decoded_instr_t;

    // ----------------------------------------------------------
    // register file selection by opcode
    // ----------------------------------------------------------
    function automatic logic is_rs1_fpr(input op_e op);
        return (op == FADD) || (op == FMADD) || (op == FCVT_F2I);
    endfunction

    function automatic logic is_rs2_fpr(input op_e op);
        return (op == FADD) || (op == FMADD);
    endfunction

    function automatic logic is_rd_fpr(input op_e op);
        return (op == FADD) || (op == FMADD) || (op == FCVT_I2F);
    endfunction

    // only the fused multiply-add reads a third operand
    function automatic logic uses_rs3(input op_e op);
        return (op == FMADD);
    endfunction

endpackage

//--- hdl/issue_fsm.sv
// issue control FSM with fence wait and flush recovery
`timescale 1ns/1ps

module issue_fsm (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    input  logic         head_valid_i,
    input  logic         inflight_full_i,
    input  logic         inflight_empty_i,
    input  logic         timer_done_i,
    input  isa_pkg::op_e head_op_i,
    output logic         issue_o,
    output logic         timer_start_o
);

    import isa_pkg::*;
    import rename_pkg::*;

    issue_state_e state_q;
    issue_state_e state_d;

    logic head_is_fence;

    assign head_is_fence = (head_op_i == FENCE);

    // ----------------------------------------------------------
    // issue decision
    // ----------------------------------------------------------
    // a fence goes out only with nothing in flight
    assign issue_o = (state_q == RUN) && head_valid_i && !inflight_full_i && !flush_i &&
                     (!head_is_fence || inflight_empty_i);

    // every flush (re)starts the quiet period
    assign timer_start_o = flush_i;

    // ----------------------------------------------------------
    // next state
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            RUN: begin
                // fence blocked by in-flight work parks here
                if (head_valid_i && head_is_fence && !inflight_empty_i) begin
                    state_d = FENCE_WAIT;
                end
            end
            FENCE_WAIT: begin
                if (inflight_empty_i) begin
                    state_d = RUN;
                end
            end
            FLUSH: begin
                if (timer_done_i) begin
                    state_d = RUN;
                end
            end
            default: state_d = RUN;
        endcase

        // flush overrides any state
        if (flush_i) begin
            state_d = FLUSH;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- hdl/recovery_timer.sv
// down-counter timing the quiet period after a flush
`timescale 1ns/1ps
`include "rename_consts.svh"

module recovery_timer (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic start_i,
    output logic done_o
);

    localparam int unsigned CNT_W = $clog2(`FLUSH_WAIT + 1);

    logic [CNT_W-1:0] count_q;

    // idle and expired look the same
    assign done_o = (count_q == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (start_i) begin
            // restart also while running
            count_q <= CNT_W'(`FLUSH_WAIT);
        end else if (!done_o) begin
            count_q <= count_q - 1'b1;
        end
    end

endmodule

//--- hdl/rename_consts.svh
// sizing, timing and feature macros for the rename and issue slice
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// ----------------------------------------------------------
// register files
// ----------------------------------------------------------
// architectural registers in each of the integer and float files
`define NR_ARCH_REGS 32

// ----------------------------------------------------------
// queues and recovery
// ----------------------------------------------------------
// decoded instructions waiting for issue
`define INSTR_QUEUE_DEPTH 4
// issued instructions not yet retired
`define MAX_INFLIGHT 4
// quiet cycles after a flush before issue resumes
`define FLUSH_WAIT 3

// 0 forces every name bit to zero
`define ENABLE_RENAME 1

`endif

//--- hdl/rename_issue.sv
// rename and issue top level wiring queues, rename tables, FSM and recovery timer
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_issue (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // decoded instruction strobe
    input  logic                  instr_valid_i,
    input  isa_pkg::op_e          instr_op_i,
    input  isa_pkg::arch_reg_t    instr_rs1_i,
    input  isa_pkg::arch_reg_t    instr_rs2_i,
    input  isa_pkg::arch_reg_t    instr_rs3_i,
    input  isa_pkg::arch_reg_t    instr_rd_i,
    output logic                  queue_full_o,
    // renamed issue strobe
    output logic                  issue_valid_o,
    output isa_pkg::op_e          issue_op_o,
    output rename_pkg::phys_reg_t issue_rs1_o,
    output rename_pkg::phys_reg_t issue_rs2_o,
    output rename_pkg::phys_reg_t issue_rs3_o,
    output rename_pkg::phys_reg_t issue_rd_o,
    // in-order retirement
    input  logic                  retire_i,
    output rename_pkg::phys_reg_t retire_rd_o,
    input  logic                  flush_i
);

    import isa_pkg::*;
    import rename_pkg::*;

    decoded_instr_t instr_in;
    decoded_instr_t head_instr;
    renamed_instr_t renamed;
    renamed_instr_t oldest;

    logic queue_empty;
    logic inflight_full;
    logic inflight_empty;
    logic issue;
    logic timer_start;
    logic timer_done;

    // gather the loose fields
    assign instr_in = '{
        op:  instr_op_i,
        rs1: instr_rs1_i,
        rs2: instr_rs2_i,
        rs3: instr_rs3_i,
        rd:  instr_rd_i
    };

    // ----------------------------------------------------------
    // instruction queue
    // ----------------------------------------------------------
    sync_fifo #(
        .T     (decoded_instr_t),
        .DEPTH (`INSTR_QUEUE_DEPTH)
    ) instr_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .push_i  (instr_valid_i),
        .pop_i   (issue),
        .data_i  (instr_in),
        .data_o  (head_instr),
        .full_o  (queue_full_o),
        .empty_o (queue_empty)
    );

    // head renamed combinationally, tables toggle on issue
    rename_table i_rename_table (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .issue_i (issue),
        .instr_i (head_instr),
        .instr_o (renamed)
    );

    // ----------------------------------------------------------
    // issue control
    // ----------------------------------------------------------
    issue_fsm i_issue_fsm (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .head_valid_i     (!queue_empty),
        .inflight_full_i  (inflight_full),
        .inflight_empty_i (inflight_empty),
        .timer_done_i     (timer_done),
        .head_op_i        (head_instr.op),
        .issue_o          (issue),
        .timer_start_o    (timer_start)
    );

    recovery_timer i_recovery_timer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .start_i (timer_start),
        .done_o  (timer_done)
    );

    // issued instructions, oldest at the head
    sync_fifo #(
        .T     (renamed_instr_t),
        .DEPTH (`MAX_INFLIGHT)
    ) inflight_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .push_i  (issue),
        .pop_i   (retire_i),
        .data_i  (renamed),
        .data_o  (oldest),
        .full_o  (inflight_full),
        .empty_o (inflight_empty)
    );

    // spread the renamed head onto the issue port
    assign issue_valid_o = issue;
    assign issue_op_o    = renamed.op;
    assign issue_rs1_o   = renamed.rs1;
    assign issue_rs2_o   = renamed.rs2;
    assign issue_rs3_o   = renamed.rs3;
    assign issue_rd_o    = renamed.rd;

    // sampled by the environment together with retire_i
    assign retire_rd_o = oldest.rd;

endmodule

//--- hdl/rename_pkg.sv
// physical register type, renamed instruction and issue state enum
package rename_pkg;

    // name bit in the msb, architectural number below it
    typedef logic [$bits(isa_pkg::arch_reg_t):0] phys_reg_t;

    // instruction after renaming, as issued and as held in flight
    typedef struct packed {
        isa_pkg::op_e op;
        phys_reg_t    rs1;
        phys_reg_t    rs2;
        phys_reg_t    rs3;
        phys_reg_t    rd;
    } renamed_instr_t;

    // ----------------------------------------------------------
    // issue control
    // ----------------------------------------------------------
    // RUN        normal issue
    // FENCE_WAIT fence at the head, draining in-flight work
    // FLUSH      quiet period after a flush
    typedef enum logic [1:0] {
        RUN        = 2'd0,
        FENCE_WAIT = 2'd1,
        FLUSH      = 2'd2
    } issue_state_e;

endpackage

//--- hdl/rename_table.sv
// integer and float rename tables extending register addresses with a name bit
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_table (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       issue_i,
    input  isa_pkg::decoded_instr_t    instr_i,
    output rename_pkg::renamed_instr_t instr_o
);

    import isa_pkg::*;
    import rename_pkg::*;

    // rename globally switched off gives all-zero name bits
    localparam logic RENAME_EN = (`ENABLE_RENAME != 0);

    // one name bit per architectural register and file
    logic [`NR_ARCH_REGS-1:0] gpr_q;
    logic [`NR_ARCH_REGS-1:0] gpr_d;
    logic [`NR_ARCH_REGS-1:0] fpr_q;
    logic [`NR_ARCH_REGS-1:0] fpr_d;

    // ----------------------------------------------------------
    // renamed view of the queue head
    // ----------------------------------------------------------
    always_comb begin
        logic bit_rs1;
        logic bit_rs2;
        logic bit_rs3;
        logic bit_rd;

        // sources read the current bit of their own file
        bit_rs1 = is_rs1_fpr(instr_i.op) ? fpr_q[instr_i.rs1] : gpr_q[instr_i.rs1];
        bit_rs2 = is_rs2_fpr(instr_i.op) ? fpr_q[instr_i.rs2] : gpr_q[instr_i.rs2];
        // third operand only meaningful for fmadd
        bit_rs3 = uses_rs3(instr_i.op) ? fpr_q[instr_i.rs3] : 1'b0;

        // destination gets the bit it will hold after this issue
        // integer x0 is never renamed
        if (is_rd_fpr(instr_i.op)) begin
            bit_rd = ~fpr_q[instr_i.rd];
        end else begin
            bit_rd = gpr_q[instr_i.rd] ^ (instr_i.rd != '0);
        end

        instr_o.op  = instr_i.op;
        instr_o.rs1 = {RENAME_EN & bit_rs1, instr_i.rs1};
        instr_o.rs2 = {RENAME_EN & bit_rs2, instr_i.rs2};
        instr_o.rs3 = {RENAME_EN & bit_rs3, instr_i.rs3};
        instr_o.rd  = {RENAME_EN & bit_rd, instr_i.rd};
    end

    // ----------------------------------------------------------
    // table update
    // ----------------------------------------------------------
    always_comb begin
        gpr_d = gpr_q;
        fpr_d = fpr_q;

        // toggle the destination of the instruction leaving now
        if (issue_i) begin
            if (is_rd_fpr(instr_i.op)) begin
                fpr_d[instr_i.rd] = ~fpr_q[instr_i.rd];
            end else begin
                gpr_d[instr_i.rd] = ~gpr_q[instr_i.rd];
            end
        end

        // x0 stays unnamed
        gpr_d[0] = 1'b0;

        // flush returns both files to their initial names
        if (flush_i) begin
            gpr_d = '0;
            fpr_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gpr_q <= '0;
            fpr_q <= '0;
        end else begin
            gpr_q <= gpr_d;
            fpr_q <= fpr_d;
        end
    end

endmodule

//--- hdl/sync_fifo.sv
// synchronous circular FIFO with a type parameter for its payload
`timescale 1ns/1ps

module sync_fifo #(
    parameter type         T     = logic,
    parameter int unsigned DEPTH = 4
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic push_i,
    input  logic pop_i,
    input  T     data_i,
    output T     data_o,
    output logic full_o,
    output logic empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // payload storage
    T mem_q [DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic do_push;
    logic do_pop;

    // push while full and pop while empty are dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign data_o  = mem_q[rd_ptr_q];

    // ----------------------------------------------------------
    // pointers and count
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // flush drops everything at once
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop keep the count
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // payload write
    always_ff @(posedge clk_i) begin
        if (do_push && !flush_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

//--- rename_issue.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/rename_pkg.sv
hdl/sync_fifo.sv
hdl/rename_table.sv
hdl/issue_fsm.sv
hdl/recovery_timer.sv
hdl/rename_issue.sv
tests/rename_issue_props.sv
tests/rename_issue_tb.sv

//--- tests/rename_issue_props.sv
// bound checker with shadow queues, shadow rename tables and concurrent assertions
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_issue_props (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  instr_valid_i,
    input isa_pkg::op_e          instr_op_i,
    input isa_pkg::arch_reg_t    instr_rs1_i,
    input isa_pkg::arch_reg_t    instr_rs2_i,
    input isa_pkg::arch_reg_t    instr_rs3_i,
    input isa_pkg::arch_reg_t    instr_rd_i,
    input logic                  queue_full_i,
    input logic                  issue_valid_i,
    input isa_pkg::op_e          issue_op_i,
    input rename_pkg::phys_reg_t issue_rs1_i,
    input rename_pkg::phys_reg_t issue_rs2_i,
    input rename_pkg::phys_reg_t issue_rs3_i,
    input rename_pkg::phys_reg_t issue_rd_i,
    input logic                  retire_i,
    input rename_pkg::phys_reg_t retire_rd_i,
    input logic                  flush_i
);

    import isa_pkg::*;
    import rename_pkg::*;

    localparam logic RN = (`ENABLE_RENAME != 0);
    localparam int   QD = `INSTR_QUEUE_DEPTH;
    localparam int   ID = `MAX_INFLIGHT;

    // failed assertions so far
    int fail_count = 0;

    // shadow name bits per file
    logic [`NR_ARCH_REGS-1:0] int_names;
    logic [`NR_ARCH_REGS-1:0] fp_names;

    // shadow instruction queue filled from the input strobes
    decoded_instr_t pend [QD];
    int             pend_head;
    int             pend_cnt;

    // renamed rd of issued instructions with the oldest first
    phys_reg_t flight_rd [ID];
    int        flight_head;
    int        flight_cnt;

    // cycles left in which issue must stay low after a flush
    int quiet_left;

    decoded_instr_t head;
    logic [3:0]     files;
    logic           accept;
    phys_reg_t      exp_rs1;
    phys_reg_t      exp_rs2;
    phys_reg_t      exp_rs3;
    phys_reg_t      exp_rd;

    // ----------------------------------------------------------
    // expected renaming of the shadow head
    // ----------------------------------------------------------
    // {rs1 float, rs2 float, rs3 used, rd float} from the opcode table
    function automatic logic [3:0] operand_files(input op_e op);
        case (op)
            FADD:     return 4'b1101;
            FMADD:    return 4'b1111;
            FCVT_F2I: return 4'b1000;
            FCVT_I2F: return 4'b0001;
            default:  return 4'b0000;
        endcase
    endfunction

    always_comb begin
        head    = pend[pend_head];
        files   = operand_files(head.op);
        exp_rs1 = {RN & (files[3] ? fp_names[head.rs1] : int_names[head.rs1]), head.rs1};
        exp_rs2 = {RN & (files[2] ? fp_names[head.rs2] : int_names[head.rs2]), head.rs2};
        exp_rs3 = {RN & files[1] & fp_names[head.rs3], head.rs3};
        if (files[0]) begin
            exp_rd = {RN & ~fp_names[head.rd], head.rd};
        end else if (head.rd == '0) begin
            // integer x0 never gets a name
            exp_rd = {1'b0, head.rd};
        end else begin
            exp_rd = {RN & ~int_names[head.rd], head.rd};
        end
    end

    assign accept = instr_valid_i && (pend_cnt < QD) && !flush_i;

    // ----------------------------------------------------------
    // shadow state update
    // ----------------------------------------------------------
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni || flush_i) begin
            int_names   <= '0;
            fp_names    <= '0;
            pend_head   <= 0;
            pend_cnt    <= 0;
            flight_head <= 0;
            flight_cnt  <= 0;
            quiet_left  <= rst_ni ? `FLUSH_WAIT : 0;
        end else begin
            if (accept) begin
                pend[(pend_head + pend_cnt) % QD] <= '{op: instr_op_i, rs1: instr_rs1_i,
                    rs2: instr_rs2_i, rs3: instr_rs3_i, rd: instr_rd_i};
            end
            if (issue_valid_i) begin
                pend_head <= (pend_head + 1) % QD;
                flight_rd[(flight_head + flight_cnt) % ID] <= exp_rd;
                // the destination flips in its own file
                if (files[0]) begin
                    fp_names[head.rd] <= ~fp_names[head.rd];
                end else if (head.rd != '0) begin
                    int_names[head.rd] <= ~int_names[head.rd];
                end
            end
            if (retire_i && flight_cnt != 0) begin
                flight_head <= (flight_head + 1) % ID;
            end
            pend_cnt   <= pend_cnt + int'(accept) - int'(issue_valid_i && pend_cnt != 0);
            flight_cnt <= flight_cnt + int'(issue_valid_i) - int'(retire_i && flight_cnt != 0);
            if (quiet_left != 0) begin
                quiet_left <= quiet_left - 1;
            end
        end
    end

    // ----------------------------------------------------------
    // assertions
    // ----------------------------------------------------------
    a_dest_name: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_valid_i |-> pend_cnt != 0 && issue_op_i == head.op && issue_rd_i == exp_rd)
        else begin
            $error("ERROR %0t: issued op %0d rd %h, expected op %0d rd %h", $time,
                $sampled(issue_op_i), $sampled(issue_rd_i), $sampled(head.op), $sampled(exp_rd));
            fail_count++;
        end

    a_source_name: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_valid_i |-> issue_rs1_i == exp_rs1 && issue_rs2_i == exp_rs2 &&
            issue_rs3_i == exp_rs3)
        else begin
            $error("ERROR %0t: issued sources %h %h %h, expected %h %h %h", $time,
                $sampled(issue_rs1_i), $sampled(issue_rs2_i), $sampled(issue_rs3_i),
                $sampled(exp_rs1), $sampled(exp_rs2), $sampled(exp_rs3));
            fail_count++;
        end

    // retire only with work in flight and the oldest rd shown
    a_retire_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
        retire_i |-> flight_cnt != 0 && retire_rd_i == flight_rd[flight_head])
        else begin
            $error("ERROR %0t: retire rd %h, expected %h with %0d in flight", $time,
                $sampled(retire_rd_i), $sampled(flight_rd[flight_head]), $sampled(flight_cnt));
            fail_count++;
        end

    a_fence_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_valid_i && issue_op_i == FENCE |-> flight_cnt == 0)
        else begin
            $error("ERROR %0t: fence issued with %0d in flight", $time, $sampled(flight_cnt));
            fail_count++;
        end

    // no issue during the flush cycle and the quiet period behind it
    a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i || quiet_left != 0 |-> !issue_valid_i)
        else begin
            $error("ERROR %0t: issue during flush recovery", $time);
            fail_count++;
        end

    a_capacity: assert property (@(posedge clk_i) disable iff (!rst_ni)
        queue_full_i == (pend_cnt == QD) && !(instr_valid_i && queue_full_i) &&
            !(issue_valid_i && flight_cnt >= ID))
        else begin
            $error("ERROR %0t: queue_full_o %0b with %0d queued, %0d in flight", $time,
                $sampled(queue_full_i), $sampled(pend_cnt), $sampled(flight_cnt));
            fail_count++;
        end

endmodule

bind rename_issue rename_issue_props u_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_op_i    (instr_op_i),
    .instr_rs1_i   (instr_rs1_i),
    .instr_rs2_i   (instr_rs2_i),
    .instr_rs3_i   (instr_rs3_i),
    .instr_rd_i    (instr_rd_i),
    .queue_full_i  (queue_full_o),
    .issue_valid_i (issue_valid_o),
    .issue_op_i    (issue_op_o),
    .issue_rs1_i   (issue_rs1_o),
    .issue_rs2_i   (issue_rs2_o),
    .issue_rs3_i   (issue_rs3_o),
    .issue_rd_i    (issue_rd_o),
    .retire_i      (retire_i),
    .retire_rd_i   (retire_rd_o),
    .flush_i       (flush_i)
);

//--- tests/rename_issue_tb.sv
// testbench for the rename and issue slice with clock, reset, seeded stimulus and final report
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_issue_tb;

    import isa_pkg::*;
    import rename_pkg::*;

    localparam time CLK_PERIOD  = 40ns;
    localparam time DRIVE_DELAY = 5ns;
    localparam int  WAIT_LIMIT  = 200;

    logic      clk_i;
    logic      rst_ni;
    logic      instr_valid_i;
    op_e       instr_op_i;
    arch_reg_t instr_rs1_i;
    arch_reg_t instr_rs2_i;
    arch_reg_t instr_rs3_i;
    arch_reg_t instr_rd_i;
    logic      queue_full_o;
    logic      issue_valid_o;
    op_e       issue_op_o;
    phys_reg_t issue_rs1_o;
    phys_reg_t issue_rs2_o;
    phys_reg_t issue_rs3_o;
    phys_reg_t issue_rd_o;
    logic      retire_i;
    phys_reg_t retire_rd_o;
    logic      flush_i;

    int seed;
    // issued minus retired, and accepted minus issued
    int in_flight = 0;
    int pending   = 0;

    rename_issue uut (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    // counts follow the ports mid-cycle, where they are settled
    always @(negedge clk_i) begin
        if (!rst_ni || flush_i) begin
            in_flight <= 0;
            pending   <= 0;
        end else begin
            in_flight <= in_flight + int'(issue_valid_o) - int'(retire_i);
            pending   <= pending + int'(instr_valid_i && !queue_full_o) - int'(issue_valid_o);
        end
    end

    task automatic abort_run(input string reason);
        $display("%s (time %0t)", reason, $time);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped after a failure");
    endtask

    // random opcode and registers, a small register range for reuse
    task automatic pick_instr();
        instr_op_i  = op_e'(3'($random(seed)));
        instr_rs1_i = arch_reg_t'($random(seed) & 7);
        instr_rs2_i = arch_reg_t'($random(seed) & 7);
        instr_rs3_i = arch_reg_t'($random(seed) & 7);
        instr_rd_i  = arch_reg_t'($random(seed) & 7);
        // stores and fences write x0
        if (instr_op_i == STORE || instr_op_i == FENCE) begin
            instr_rd_i = '0;
        end
    endtask

    // one cycle of stimulus, driven shortly after the rising edge
    task automatic drive_cycle(input bit want_instr, input bit want_retire, input bit do_flush);
        @(posedge clk_i);
        #(DRIVE_DELAY);
        instr_valid_i = 1'b0;
        retire_i      = 1'b0;
        flush_i       = do_flush;
        if (want_instr && !queue_full_o && !do_flush) begin
            pick_instr();
            instr_valid_i = 1'b1;
        end
        if (want_retire && in_flight != 0 && !do_flush) begin
            retire_i = 1'b1;
        end
    endtask

    // fixed instruction, sent once the queue has room
    task automatic send_instr(input op_e op, input arch_reg_t reg_num);
        int waited;
        waited = 0;
        drive_cycle(1'b0, 1'b0, 1'b0);
        while (queue_full_o && waited < WAIT_LIMIT) begin
            drive_cycle(1'b0, 1'b0, 1'b0);
            waited++;
        end
        if (queue_full_o) begin
            abort_run("instruction queue stayed full");
        end else begin
            instr_op_i    = op;
            instr_rs1_i   = reg_num;
            instr_rs2_i   = reg_num;
            instr_rs3_i   = reg_num;
            instr_rd_i    = (op == FENCE) ? arch_reg_t'(0) : reg_num;
            instr_valid_i = 1'b1;
        end
    endtask

    // retire at random until nothing is queued or in flight
    task automatic drain_all();
        int waited;
        waited = 0;
        drive_cycle(1'b0, 1'b0, 1'b0);
        while ((pending != 0 || in_flight != 0) && waited < WAIT_LIMIT) begin
            drive_cycle(1'b0, ($random(seed) & 1) != 0, 1'b0);
            waited++;
        end
        if (pending != 0 || in_flight != 0) begin
            abort_run("queues did not drain before the timeout");
        end
    endtask

    initial begin : failure_watch
        wait (uut.u_props.fail_count != 0);
        abort_run("an assertion on the DUT ports failed");
    end

    initial begin : watchdog
        repeat (3000) @(posedge clk_i);
        abort_run("simulation did not finish in time");
    end

    initial begin : stimulus
        seed          = 76;
        rst_ni        = 1'b0;
        instr_valid_i = 1'b0;
        instr_op_i    = ALU;
        instr_rs1_i   = '0;
        instr_rs2_i   = '0;
        instr_rs3_i   = '0;
        instr_rd_i    = '0;
        retire_i      = 1'b0;
        flush_i       = 1'b0;

        repeat (2) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_ni = 1'b1;

        // ----------------------------------------------------------
        // mixed traffic, flushes at fixed cycles
        // ----------------------------------------------------------
        for (int cyc = 0; cyc < 160; cyc++) begin
            drive_cycle(($random(seed) & 3) != 0, ($random(seed) & 1) != 0,
                cyc == 50 || cyc == 110);
        end
        drain_all();

        // ----------------------------------------------------------
        // fence behind a full in-flight queue, then a full instruction queue
        // ----------------------------------------------------------
        for (int n = 1; n <= 4; n++) begin
            send_instr(ALU, arch_reg_t'(n));
        end
        send_instr(FENCE, '0);
        for (int n = 1; n <= 3; n++) begin
            send_instr(FADD, arch_reg_t'(n));
        end
        // nothing retires, so the fence has to wait
        repeat (8) drive_cycle(1'b0, 1'b0, 1'b0);
        drain_all();
        repeat (2) drive_cycle(1'b0, 1'b0, 1'b0);

        if (uut.u_props.fail_count != 0) begin
            abort_run("assertion failures were recorded");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule
